/* hdl/der_active_regs.sv */
// Level-2 active register set
// Whole level-1 set captured in one cycle on load_actvn
// Engine reads these while the host refills level 1

`timescale 1ns/100ps

module der_active_regs (
  input  logic                de_clk,      // Drawing engine clock
  input  logic                rst_n,       // Async reset, low active
  input  logic                load_actvn,  // Low one cycle from dispatcher
  input  der_pkg::der_regs_t  regs_1,      // Level-1 set from host side
  output der_pkg::der_regs_t  regs_2       // Active set for the engine
);

  //////////////////////
  // Level-2 capture
  //////////////////////
  // Held between loads, so a host write to level 1 never
  // reaches a command already handed to the engine
  always_ff @(posedge de_clk or negedge rst_n) begin
    if (!rst_n) begin
      regs_2 <= '0;                        // Reads as all zero after reset
    end else if (!load_actvn) begin
      regs_2 <= regs_1;                    // Edge ending the LOAD cycle
    end
  end

endmodule

/* hdl/der_dispatch.sv */
// Command dispatcher FSM
// IDLE -> LOAD -> GO -> WAIT per ready command
// Load strobe and acknowledge in LOAD, line/BLT start in GO
// Next command held off until the engine drops busy

`timescale 1ns/100ps

module der_dispatch (
  input  logic               de_clk,       // Drawing engine clock
  input  logic               rst_n,        // Async reset, low active
  input  logic               cmdrdy,       // Level 1 holds a command
  input  logic               dex_busy,     // Engine executing
  input  der_pkg::der_opc_e  opc_1,        // Level-1 opcode
  output logic               cmdack,       // One cycle, clears cmdrdy
  output logic               load_actvn,   // Low one cycle, copy L1 to L2
  output logic               goline,       // Start 2D line
  output logic               goblt,        // Start 2D BLT
  output logic               engine_busy   // Dispatcher not idle
);

  der_pkg::der_state_e  state;             // Current state
  der_pkg::der_state_e  state_nxt;         // Next state
  der_pkg::der_opc_e    opc_2;             // Opcode of the loaded command
  logic                 is_draw;           // L1 opcode starts the engine

  assign is_draw = (opc_1 == der_pkg::OPC_LINE) || (opc_1 == der_pkg::OPC_BLT);

  //////////////////////
  // State register
  //////////////////////
  always_ff @(posedge de_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= der_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Opcode follows the loaded set, not later host writes
  always_ff @(posedge de_clk or negedge rst_n) begin
    if (!rst_n) begin
      opc_2 <= der_pkg::OPC_NOOP;
    end else if (state == der_pkg::LOAD) begin
      opc_2 <= opc_1;                      // L1 is frozen while cmdrdy
    end
  end

  //////////////////////
  // Next state
  //////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      der_pkg::IDLE: begin
        if (cmdrdy) begin
          state_nxt = der_pkg::LOAD;
        end
      end
      der_pkg::LOAD: begin
        // No-op and unknown opcodes only load level 2
        state_nxt = is_draw ? der_pkg::GO : der_pkg::IDLE;
      end
      der_pkg::GO: begin
        state_nxt = der_pkg::WAIT;         // Engine sees go this cycle
      end
      der_pkg::WAIT: begin
        if (!dex_busy) begin
          state_nxt = der_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = der_pkg::IDLE;
      end
    endcase
  end

  //////////////////////
  // Outputs
  //////////////////////
  assign cmdack      = (state == der_pkg::LOAD);
  assign load_actvn  = (state != der_pkg::LOAD);                  // Low active
  assign goline      = (state == der_pkg::GO) && (opc_2 == der_pkg::OPC_LINE);
  assign goblt       = (state == der_pkg::GO) && (opc_2 == der_pkg::OPC_BLT);
  assign engine_busy = (state != der_pkg::IDLE);

endmodule

/* hdl/der_host_regs.sv */
// Level-1 host register set
// Address decode with per-byte write enables
// Command-ready flag, set by an XY4 write, cleared by cmdack
// Host writes are dropped while a command is pending

`timescale 1ns/100ps

module der_host_regs (
  input  logic                   de_clk,   // Drawing engine clock
  input  logic                   rst_n,    // Async reset, low active
  input  der_pkg::der_host_wr_t  host,     // Host bus cycle
  input  logic                   cmdack,   // Dispatcher took the command
  output der_pkg::der_regs_t     regs_1,   // Level-1 register set
  output logic                   cmdrdy    // Command waiting for dispatch
);

  localparam int DW = der_pkg::DER_DATA_W;

  der_pkg::der_addr_e  wr_adr;             // Decoded host address
  logic                wr_en;              // Accepted host write
  logic [DW-1:0]       cur_w;              // Current word at wr_adr
  logic [DW-1:0]       new_w;              // Word after byte merge

  // Replace only the enabled bytes
  function automatic logic [DW-1:0] merge_bytes(
    input logic [DW-1:0] old_w,
    input logic [DW-1:0] din,
    input logic [3:0]    ben
  );
    logic [DW-1:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (ben[i]) begin
        res[8*i +: 8] = din[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign wr_adr = der_pkg::der_addr_e'(host.adr);
  assign wr_en  = ~host.csn & host.wstrb & ~cmdrdy;  // Back-pressure while pending

  //////////////////////
  // Word view of the addressed register
  //////////////////////
  always_comb begin
    cur_w = '0;
    case (wr_adr)
      der_pkg::BUF_CTRL: cur_w[11:0] = regs_1.buf_ctrl;
      der_pkg::SORG:     cur_w       = regs_1.sorg;
      der_pkg::DORG:     cur_w       = regs_1.dorg;
      der_pkg::PTCH: begin
        cur_w[11:0]                           = regs_1.sptch;
        cur_w[der_pkg::PTCH_DPTCH_LSB +: 12]  = regs_1.dptch;
      end
      der_pkg::CMD: begin
        cur_w[3:0]                            = regs_1.opc;
        cur_w[der_pkg::CMD_ROP_LSB +: 4]      = regs_1.rop;
        cur_w[der_pkg::CMD_STYLE_LSB +: 5]    = regs_1.style;
        cur_w[der_pkg::CMD_APAT_LSB +: 2]     = regs_1.apat;
        cur_w[der_pkg::CMD_CLP_LSB +: 3]      = regs_1.clp;
      end
      der_pkg::FORE:     cur_w       = regs_1.fore;
      der_pkg::BACK:     cur_w       = regs_1.back;
      der_pkg::MASK_KEY: begin
        cur_w[23:0]                           = regs_1.key;
        cur_w[der_pkg::MK_MASK_LSB +: 4]      = regs_1.mask;
      end
      der_pkg::XY0, der_pkg::XY1, der_pkg::XY2,
      der_pkg::XY3, der_pkg::XY4: cur_w = regs_1.xy[host.adr[2:0]];
      default:           cur_w       = '0;    // STATUS and holes
    endcase
  end

  assign new_w = merge_bytes(cur_w, host.din, host.ben);

  //////////////////////
  // Level-1 registers
  //////////////////////
  always_ff @(posedge de_clk or negedge rst_n) begin
    if (!rst_n) begin
      regs_1 <= '0;
    end else if (wr_en) begin
      case (wr_adr)
        der_pkg::BUF_CTRL: regs_1.buf_ctrl <= new_w[11:0];
        der_pkg::SORG:     regs_1.sorg     <= new_w;
        der_pkg::DORG:     regs_1.dorg     <= new_w;
        der_pkg::PTCH: begin
          regs_1.sptch <= new_w[11:0];
          regs_1.dptch <= new_w[der_pkg::PTCH_DPTCH_LSB +: 12];
        end
        der_pkg::CMD: begin
          regs_1.opc   <= new_w[3:0];
          regs_1.rop   <= new_w[der_pkg::CMD_ROP_LSB +: 4];
          regs_1.style <= new_w[der_pkg::CMD_STYLE_LSB +: 5];
          regs_1.apat  <= new_w[der_pkg::CMD_APAT_LSB +: 2];
          regs_1.clp   <= new_w[der_pkg::CMD_CLP_LSB +: 3];
        end
        der_pkg::FORE:     regs_1.fore     <= new_w;
        der_pkg::BACK:     regs_1.back     <= new_w;
        der_pkg::MASK_KEY: begin
          regs_1.key  <= new_w[23:0];
          regs_1.mask <= new_w[der_pkg::MK_MASK_LSB +: 4];
        end
        der_pkg::XY0, der_pkg::XY1, der_pkg::XY2,
        der_pkg::XY3, der_pkg::XY4: regs_1.xy[host.adr[2:0]] <= new_w;  // 0x08 + n
        default: ;                                             // Read only or unmapped
      endcase
    end
  end

  // Command ready handshake
  always_ff @(posedge de_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmdrdy <= 1'b0;
    end else if (cmdack) begin
      cmdrdy <= 1'b0;                                        // Ends with the LOAD cycle
    end else if (wr_en && wr_adr == der_pkg::XY4) begin
      cmdrdy <= 1'b1;                                        // Last XY word kicks it
    end
  end

endmodule

/* hdl/der_pkg.sv */
// Shared definitions for the drawing engine register block
// Host word address map and drawing opcodes
// Command dispatcher states
// Bit positions of fields inside packed host words
// Level-1/level-2 register set and host bus cycle structs

package der_pkg;

  localparam int DER_DATA_W = 32;          // Host data bus width

  //////////////////////
  // Host address map
  //////////////////////
  typedef enum logic [6:0] {
    BUF_CTRL = 7'h00,                      // Buffer control
    SORG     = 7'h01,                      // Source origin
    DORG     = 7'h02,                      // Destination origin
    PTCH     = 7'h03,                      // Source/dest pitch
    CMD      = 7'h04,                      // Command word
    FORE     = 7'h05,                      // Foreground color
    BACK     = 7'h06,                      // Background color
    MASK_KEY = 7'h07,                      // Plane mask and color key
    XY0      = 7'h08,                      // XY words, XY4 kicks the command
    XY1      = 7'h09,
    XY2      = 7'h0A,
    XY3      = 7'h0B,
    XY4      = 7'h0C,
    STATUS   = 7'h0F                       // Read only
  } der_addr_e;

  typedef enum logic [3:0] {
    OPC_NOOP = 4'h0,                       // Load only, engine idle
    OPC_BLT  = 4'h1,                       // 2D BLT
    OPC_LINE = 4'h2                        // 2D line
  } der_opc_e;

  typedef enum logic [1:0] {
    IDLE,                                  // Waiting for cmdrdy
    LOAD,                                  // Copy L1 to L2, ack host
    GO,                                    // Start pulse to engine
    WAIT                                   // Engine running
  } der_state_e;

  //////////////////////
  // Packed word layout
  //////////////////////
  localparam int PTCH_DPTCH_LSB = 16;      // sptch sits at bit 0
  localparam int CMD_ROP_LSB    = 4;       // opc sits at bit 0
  localparam int CMD_STYLE_LSB  = 8;
  localparam int CMD_APAT_LSB   = 13;
  localparam int CMD_CLP_LSB    = 16;
  localparam int MK_MASK_LSB    = 24;      // key sits at bit 0
  localparam int STAT_BUSY_HB   = 0;       // Status bit, level 1 held
  localparam int STAT_ENG_BUSY  = 1;       // Status bit, dispatcher active

  // One full register set, level 1 or level 2
  typedef struct packed {
    logic [11:0]                 buf_ctrl;
    logic [DER_DATA_W-1:0]       sorg;
    logic [DER_DATA_W-1:0]       dorg;
    logic [11:0]                 sptch;    // PTCH low half
    logic [11:0]                 dptch;    // PTCH high half
    logic [3:0]                  opc;
    logic [3:0]                  rop;
    logic [4:0]                  style;
    logic [1:0]                  apat;
    logic [2:0]                  clp;
    logic [DER_DATA_W-1:0]       fore;
    logic [DER_DATA_W-1:0]       back;
    logic [3:0]                  mask;
    logic [23:0]                 key;
    logic [4:0][DER_DATA_W-1:0]  xy;       // xy[n] at address XY0 + n
  } der_regs_t;

  // One host bus cycle
  typedef struct packed {
    logic                        csn;      // Chip select, low active
    logic                        wstrb;    // Write strobe
    logic [6:0]                  adr;      // Word address
    logic [3:0]                  ben;      // Byte enables
    logic [DER_DATA_W-1:0]       din;      // Write data
  } der_host_wr_t;

endpackage

/* hdl/der_rdmux.sv */
// Host read-back multiplexer
// Level-1 registers by word address, zero-extended
// Packed PTCH, CMD and MASK_KEY words rebuilt from fields
// Status word with host busy and engine busy bits

`timescale 1ns/100ps

module der_rdmux (
  input  der_pkg::der_addr_e              hb_adr,       // Host read address
  input  der_pkg::der_regs_t              regs_1,       // Level-1 set
  input  logic                            busy_hb,      // Command pending
  input  logic                            engine_busy,  // Dispatcher active
  output logic [der_pkg::DER_DATA_W-1:0]  hb_dout       // Read data, same cycle
);

  //////////////////////
  // Read select
  //////////////////////
  always_comb begin
    hb_dout = '0;                          // Unused bits read zero
    case (hb_adr)
      der_pkg::BUF_CTRL: hb_dout[11:0] = regs_1.buf_ctrl;
      der_pkg::SORG:     hb_dout       = regs_1.sorg;
      der_pkg::DORG:     hb_dout       = regs_1.dorg;
      der_pkg::PTCH: begin
        hb_dout[11:0]                          = regs_1.sptch;
        hb_dout[der_pkg::PTCH_DPTCH_LSB +: 12] = regs_1.dptch;
      end
      der_pkg::CMD: begin
        hb_dout[3:0]                           = regs_1.opc;
        hb_dout[der_pkg::CMD_ROP_LSB +: 4]     = regs_1.rop;
        hb_dout[der_pkg::CMD_STYLE_LSB +: 5]   = regs_1.style;
        hb_dout[der_pkg::CMD_APAT_LSB +: 2]    = regs_1.apat;
        hb_dout[der_pkg::CMD_CLP_LSB +: 3]     = regs_1.clp;
      end
      der_pkg::FORE:     hb_dout       = regs_1.fore;
      der_pkg::BACK:     hb_dout       = regs_1.back;
      der_pkg::MASK_KEY: begin
        hb_dout[23:0]                          = regs_1.key;
        hb_dout[der_pkg::MK_MASK_LSB +: 4]     = regs_1.mask;
      end
      der_pkg::XY0:      hb_dout       = regs_1.xy[0];
      der_pkg::XY1:      hb_dout       = regs_1.xy[1];
      der_pkg::XY2:      hb_dout       = regs_1.xy[2];
      der_pkg::XY3:      hb_dout       = regs_1.xy[3];
      der_pkg::XY4:      hb_dout       = regs_1.xy[4];
      der_pkg::STATUS: begin
        hb_dout[der_pkg::STAT_BUSY_HB]  = busy_hb;      // Poll before next write
        hb_dout[der_pkg::STAT_ENG_BUSY] = engine_busy;  // Falls at command end
      end
      default:           hb_dout       = '0;            // Unmapped holes
    endcase
  end

endmodule

/* hdl/der_top.sv */
// Drawing engine register block, top level
// Level-1 host registers, command dispatcher
// Level-2 active registers, host read-back mux
// Single clock domain on de_clk

`timescale 1ns/100ps

module der_top (
  input  logic                            de_clk,      // Drawing engine clock
  input  logic                            rst_n,       // Async reset, low active
  input  der_pkg::der_host_wr_t           host,        // Host bus cycle
  input  logic                            dex_busy,    // Engine executing
  output logic [der_pkg::DER_DATA_W-1:0]  hb_dout,     // Host read data
  output logic                            busy_hb,     // Level 1 held
  output logic                            goline,      // Start 2D line
  output logic                            goblt,       // Start 2D BLT
  output logic                            load_actvn,  // L1 to L2 strobe
  output der_pkg::der_regs_t              regs_2       // Active set
);

  der_pkg::der_regs_t  regs_1;             // Host side set
  logic                cmdrdy;             // Command pending
  logic                cmdack;             // Dispatcher took it
  logic                engine_busy;        // Dispatcher not idle

  assign busy_hb = cmdrdy;                 // Host waits on the pending flag

  //////////////////////
  // Level 1
  //////////////////////
  der_host_regs u_der_host_regs (
    .de_clk       (de_clk),
    .rst_n        (rst_n),
    .host         (host),
    .cmdack       (cmdack),
    .regs_1       (regs_1),
    .cmdrdy       (cmdrdy)
  );

  //////////////////////
  // Dispatcher
  //////////////////////
  der_dispatch u_der_dispatch (
    .de_clk       (de_clk),
    .rst_n        (rst_n),
    .cmdrdy       (cmdrdy),
    .dex_busy     (dex_busy),
    .opc_1        (der_pkg::der_opc_e'(regs_1.opc)),
    .cmdack       (cmdack),
    .load_actvn   (load_actvn),
    .goline       (goline),
    .goblt        (goblt),
    .engine_busy  (engine_busy)
  );

  // Level 2
  der_active_regs u_der_active_regs (
    .de_clk       (de_clk),
    .rst_n        (rst_n),
    .load_actvn   (load_actvn),
    .regs_1       (regs_1),
    .regs_2       (regs_2)
  );

  // Read back
  der_rdmux u_der_rdmux (
    .hb_adr       (der_pkg::der_addr_e'(host.adr)),
    .regs_1       (regs_1),
    .busy_hb      (cmdrdy),
    .engine_busy  (engine_busy),
    .hb_dout      (hb_dout)
  );

endmodule

/* sources.f */
hdl/der_pkg.sv
hdl/der_host_regs.sv
hdl/der_dispatch.sv
hdl/der_active_regs.sv
hdl/der_rdmux.sv
hdl/der_top.sv
verification/der_tb.sv

/* verification/der_tb.sv */
// Testbench for the drawing engine register block
// Host bus driven from a test file, engine busy model
// Level-1 word model and expected level-2 set
// Load and go pulse timing, back-pressure and read-back checks
// Watchdog scaled to the test file length

`timescale 1ns/100ps

module der_tb;

  logic                   de_clk;
  logic                   rst_n;
  der_pkg::der_host_wr_t  host;
  logic                   dex_busy = 1'b0;       // Engine model output
  logic [31:0]            hb_dout;
  logic                   busy_hb;
  logic                   goline;
  logic                   goblt;
  logic                   load_actvn;
  der_pkg::der_regs_t     regs_2;

  logic [31:0]         l1 [0:127];               // Level-1 model in host word view
  der_pkg::der_regs_t  exp_l2 = '0;              // Expected level 2
  logic [31:0]         lcg_state = 32'h0679_d55e;
  int                  n_lines = 0;              // Test file length
  int                  busy_len = 1;             // Engine hold for next go
  int                  eng_left = 0;             // Engine cycles still busy
  logic                eng_idle = 1'b1;          // Dispatcher known idle
  logic                pend = 1'b0;              // XY4 written and load not yet checked

  der_top dut (
    .de_clk     (de_clk),
    .rst_n      (rst_n),
    .host       (host),
    .dex_busy   (dex_busy),
    .hb_dout    (hb_dout),
    .busy_hb    (busy_hb),
    .goline     (goline),
    .goblt      (goblt),
    .load_actvn (load_actvn),
    .regs_2     (regs_2)
  );

  initial begin
    de_clk = 1'b0;
    forever #4 de_clk = ~de_clk;                 // 8 ns period
  end

  // Engine model holds busy from the go pulse for busy_len cycles
  always @(negedge de_clk) begin
    if (eng_left > 0) begin
      eng_left = eng_left - 1;
      if (eng_left == 0) begin
        dex_busy = 1'b0;
      end
    end else if (goline || goblt) begin
      dex_busy = 1'b1;
      eng_left = busy_len;
    end
  end

  //////////////////////
  // Helpers
  //////////////////////
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bits of each host word backed by a register field
  function automatic logic [31:0] field_mask(input logic [6:0] adr);
    case (adr)
      der_pkg::BUF_CTRL: return 32'h0000_0fff;
      der_pkg::PTCH:     return 32'h0fff_0fff;   // sptch and dptch
      der_pkg::CMD:      return 32'h0007_7fff;   // opc rop style apat clp
      der_pkg::MASK_KEY: return 32'h0fff_ffff;   // key and mask
      der_pkg::SORG, der_pkg::DORG, der_pkg::FORE, der_pkg::BACK,
      der_pkg::XY0, der_pkg::XY1, der_pkg::XY2, der_pkg::XY3,
      der_pkg::XY4:      return 32'hffff_ffff;
      default:           return 32'h0;           // STATUS and holes
    endcase
  endfunction

  task automatic model_write(input logic [6:0] adr, input logic [3:0] ben, input logic [31:0] d);
    for (int i = 0; i < 4; i++) begin
      if (ben[i]) begin
        l1[adr][8*i +: 8] = d[8*i +: 8];
      end
    end
    l1[adr] = l1[adr] & field_mask(adr);
  endtask

  // Expected register set built from the word model
  function automatic der_pkg::der_regs_t model_regs();
    der_pkg::der_regs_t r;
    r.buf_ctrl = l1[der_pkg::BUF_CTRL][11:0];
    r.sorg     = l1[der_pkg::SORG];
    r.dorg     = l1[der_pkg::DORG];
    r.sptch    = l1[der_pkg::PTCH][11:0];
    r.dptch    = l1[der_pkg::PTCH][27:16];
    r.opc      = l1[der_pkg::CMD][3:0];
    r.rop      = l1[der_pkg::CMD][7:4];
    r.style    = l1[der_pkg::CMD][12:8];
    r.apat     = l1[der_pkg::CMD][14:13];
    r.clp      = l1[der_pkg::CMD][18:16];
    r.fore     = l1[der_pkg::FORE];
    r.back     = l1[der_pkg::BACK];
    r.key      = l1[der_pkg::MASK_KEY][23:0];
    r.mask     = l1[der_pkg::MASK_KEY][27:24];
    for (int n = 0; n < 5; n++) begin
      r.xy[n] = l1[8 + n];
    end
    return r;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      report_fail($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_regs2(input der_pkg::der_regs_t exp);
    assert (regs_2 === exp) else begin
      report_fail($sformatf("[ERROR] regs_2 got 0x%h expected 0x%h", regs_2, exp));
    end
  endtask

  // Called at a falling edge and returns one cycle later
  task automatic host_write(input logic [6:0] adr, input logic [3:0] ben, input logic [31:0] d);
    host.csn   = 1'b0;
    host.wstrb = 1'b1;
    host.adr   = adr;
    host.ben   = ben;
    host.din   = d;
    @(negedge de_clk);
    host.csn   = 1'b1;
    host.wstrb = 1'b0;
    host.ben   = 4'h0;
    host.adr   = der_pkg::STATUS;                // Idle bus polls status
  endtask

  // Wait for the pending load and then check the go pulse and level 2
  task automatic finish_cmd();
    int         n;
    logic       saw_idle;
    logic [3:0] opc;
    logic       draw;
    n        = 0;
    saw_idle = 1'b0;
    opc      = l1[der_pkg::CMD][3:0];
    draw     = (opc == der_pkg::OPC_LINE) || (opc == der_pkg::OPC_BLT);
    host.adr = der_pkg::STATUS;
    assert (load_actvn) else begin
      report_fail("Command was loaded before the testbench started waiting for it");
    end
    while (load_actvn) begin
      @(negedge de_clk);
      n++;
      if (!hb_dout[der_pkg::STAT_ENG_BUSY]) begin
        saw_idle = 1'b1;                         // Dispatcher passed through IDLE
      end
      check_equal("goline|goblt before load", goline | goblt, 0);
      check_regs2(exp_l2);                       // L2 holds until the load edge
    end
    if (eng_idle) begin
      check_equal("XY4 write to load_actvn cycles", n, 1);
    end else begin
      assert (saw_idle) else begin
        report_fail("Next command loaded before engine_busy fell");
      end
    end
    check_equal("busy_hb in LOAD", busy_hb, 1);
    @(negedge de_clk);
    exp_l2 = model_regs();
    check_regs2(exp_l2);
    check_equal("busy_hb after cmdack", busy_hb, 0);
    check_equal("goline", goline, opc == der_pkg::OPC_LINE);
    check_equal("goblt", goblt, opc == der_pkg::OPC_BLT);
    if (draw) begin
      @(negedge de_clk);
      check_equal("goline|goblt after pulse", goline | goblt, 0);  // One cycle only
    end
    eng_idle = !draw;
    pend     = 1'b0;
  endtask

  //////////////////////
  // Main sequence
  //////////////////////
  initial begin
    int          fd;
    int          cnt;
    int          opc;
    int          cycles;
    string       op;
    string       dstr;
    string       line;
    logic [6:0]  adr;
    logic [3:0]  ben;
    logic [31:0] data;
    rst_n    = 1'b0;
    host     = '0;
    host.csn = 1'b1;
    for (int i = 0; i < 128; i++) begin
      l1[i] = '0;
    end
    fd = $fopen("verification/der_tests.txt", "r");
    if (fd == 0) begin
      report_fail("Cannot open verification/der_tests.txt");
    end
    cnt = 0;
    while ($fgets(line, fd) > 0) begin
      cnt++;
    end
    n_lines = cnt;                               // Watchdog length, set once
    $fclose(fd);
    fd = $fopen("verification/der_tests.txt", "r");
    repeat (16) @(posedge de_clk);               // Reset held 16 cycles
    @(negedge de_clk);
    rst_n = 1'b1;
    @(negedge de_clk);
    check_equal("load_actvn after reset", load_actvn, 1);
    check_equal("goline after reset", goline, 0);
    check_equal("goblt after reset", goblt, 0);
    check_equal("busy_hb after reset", busy_hb, 0);
    check_regs2('0);
    for (int a = 0; a < 16; a++) begin
      host.adr = a;
      @(negedge de_clk);
      check_equal($sformatf("hb_dout @0x%h after reset", a), hb_dout, 0);
    end
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op.substr(0, 0) == "#") begin
        cnt = $fgets(line, fd);                  // Column description
      end else if (op == "W" || op == "F") begin
        cnt = $fscanf(fd, "%h %h %s", adr, ben, dstr);
        if (cnt != 3) begin
          report_fail("Write line in the test file is incomplete");
        end
        if (dstr == "*") begin
          data = next_rand();
        end else begin
          cnt = $sscanf(dstr, "%h", data);
          if (cnt != 1) begin
            report_fail("Write data in the test file is not hex");
          end
        end
        if (op == "W") begin
          if (pend) begin
            finish_cmd();
          end
          while (busy_hb) @(negedge de_clk);
          host_write(adr, ben, data);
          model_write(adr, ben, data);
        end else begin
          assert (busy_hb) else begin
            report_fail("Forced write issued while busy_hb is low");
          end
          host_write(adr, ben, data);            // Must be dropped
        end
      end else if (op == "R") begin
        cnt = $fscanf(fd, "%h %s", adr, dstr);
        if (cnt != 2) begin
          report_fail("Read line in the test file is incomplete");
        end
        if (dstr == "*") begin
          data = l1[adr];
        end else begin
          cnt = $sscanf(dstr, "%h", data);
          if (cnt != 1) begin
            report_fail("Read value in the test file is not hex");
          end
        end
        host.adr = adr;
        @(negedge de_clk);
        check_equal($sformatf("hb_dout @0x%h", adr), hb_dout, data);
      end else if (op == "X") begin
        cnt = $fscanf(fd, "%h %d", opc, cycles);
        if (cnt != 2) begin
          report_fail("Command line in the test file is incomplete");
        end
        if (pend) begin
          finish_cmd();
        end
        while (busy_hb) @(negedge de_clk);
        assert (opc == l1[der_pkg::CMD][3:0]) else begin
          report_fail("Opcode in the test file differs from the CMD register model");
        end
        busy_len = cycles;
        data     = next_rand();
        host_write(der_pkg::XY4, 4'hf, data);
        model_write(der_pkg::XY4, 4'hf, data);
        check_equal("busy_hb after XY4 write", busy_hb, 1);
        pend = 1'b1;
        if (eng_idle) begin
          finish_cmd();                          // Exact timing from idle
        end
      end else if (op == "S") begin
        if (pend) begin
          finish_cmd();
        end
        host.adr = der_pkg::STATUS;
        do begin
          @(negedge de_clk);
        end while (hb_dout[der_pkg::STAT_ENG_BUSY]);
        eng_idle = 1'b1;
      end else begin
        report_fail($sformatf("Unknown operation %s in the test file", op));
      end
    end
    if (pend) begin
      finish_cmd();
    end
    $fclose(fd);
    $display("PASS: all tests");
    $finish;
  end

  // Watchdog
  initial begin
    wait (n_lines > 0);
    repeat (n_lines * 64) @(posedge de_clk);
    report_fail($sformatf("Timeout, run did not finish within %0d cycles", n_lines * 64));
  end

endmodule

/* verification/der_tests.txt */
# W/F adr ben data : host write, or forced write while busy (data * = LCG word)
# R adr expected (* = level-1 model) | X opcode busy_cycles | S wait for engine idle
W 00 f *
R 00 *
W 01 3 *
W 01 c 12345678
R 01 *
W 02 f *
R 02 *
W 03 f ffffffff
R 03 0fff0fff
W 03 2 00000000
R 03 0fff00ff
W 04 f fffff0f2
R 04 000770f2
W 05 5 *
W 05 a *
R 05 *
W 06 f *
R 06 *
W 07 f ffffffff
R 07 0fffffff
W 07 8 a0000000
R 07 00ffffff
W 08 f *
W 09 f *
W 0a 6 *
R 0a *
W 0b f *
X 2 5
R 0c *
S
R 0f 0
W 04 1 00000001
R 04 00077001
X 1 40
W 01 f *
W 03 3 *
W 04 1 00000002
W 09 f *
X 2 3
F 01 f deadbeef
R 01 *
R 0f 3
S
W 04 1 00000000
X 0 2
R 0f 0
W 0d f 11111111
R 0d 0
S
